/* obi_pkg.sv */
/*
 * OBI signal widths and requestor count shared by the memory subsystem
 * and its testbench. Import where port or bus widths are needed.
 */
package obi_pkg;

  // Byte address width of every requestor port
  localparam int unsigned AddrWidth = 32;

  // Data bus width, one word per transfer
  localparam int unsigned DataWidth = 32;

  // One enable per data byte
  localparam int unsigned BeWidth = DataWidth / 8;

  // Requestors sharing the banks, e.g. instruction and data port of a core
  localparam int unsigned NumMasters = 2;

endpackage

/* mem_map_pkg.sv */
/*
 * Memory map of the banked data memory: size, bank split, address slicing
 * and the per-bank arbitration priority type.
 */
package mem_map_pkg;

  // Total memory size in bytes
  localparam int unsigned NumBytes = 16384;

  // Single-ported SRAM banks, each covering a contiguous slice
  localparam int unsigned NumBanks = 8;

  // Words held by one bank
  localparam int unsigned BankWords = NumBytes / 4 / NumBanks;

  // Word index inside a bank sits in address bits 10:2
  localparam int unsigned WordIdxWidth = 9;
  localparam int unsigned WordLsb = 2;

  // Bank index sits in address bits 13:11, upper bits alias
  localparam int unsigned BankIdxWidth = 3;
  localparam int unsigned BankLsb = WordLsb + WordIdxWidth;

  // Requestor that wins the next conflict on a bank
  typedef enum logic {
    PrioM0,
    PrioM1
  } prio_e;

endpackage

/* sram_wrapper.sv */
/*
 * One single-port SRAM bank. Writes honour byte enables, reads return the
 * addressed word one cycle after the strobe and hold it until the next read.
 */
`timescale 1ns/10ps

module sram_wrapper (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [mem_map_pkg::WordIdxWidth-1:0] addr_i,
  input  logic [obi_pkg::DataWidth-1:0]        wdata_i,
  input  logic [obi_pkg::BeWidth-1:0]          be_i,
  output logic [obi_pkg::DataWidth-1:0]        rdata_o
);

  import obi_pkg::*;
  import mem_map_pkg::*;

  logic [DataWidth-1:0] mem_q [BankWords];
  logic [DataWidth-1:0] rdata_q;

  // Byte-wise write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (be_i[i]) begin
          mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i]; // Held across writes and idle cycles
    end
  end

  assign rdata_o = rdata_q;

  // A strobe with an unknown address or direction would corrupt the bank
  a_strobe_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown({addr_i, we_i})
  );

endmodule

/* bank_crossbar.sv */
/*
 * Request stage. Decodes the bank of each requestor, arbitrates conflicts
 * round-robin per bank, drives the bank strobes and records every grant.
 */
`timescale 1ns/10ps

module bank_crossbar (
  input  logic                                                             clk_i,
  input  logic                                                             rst_ni,
  input  logic [obi_pkg::NumMasters-1:0]                                   mst_req_i,
  input  logic [obi_pkg::NumMasters-1:0]                                   mst_we_i,
  input  logic [obi_pkg::NumMasters-1:0][obi_pkg::AddrWidth-1:0]           mst_addr_i,
  input  logic [obi_pkg::NumMasters-1:0][obi_pkg::BeWidth-1:0]             mst_be_i,
  input  logic [obi_pkg::NumMasters-1:0][obi_pkg::DataWidth-1:0]           mst_wdata_i,
  output logic [obi_pkg::NumMasters-1:0]                                   mst_gnt_o,
  output logic [mem_map_pkg::NumBanks-1:0]                                 bank_req_o,
  output logic [mem_map_pkg::NumBanks-1:0]                                 bank_we_o,
  output logic [mem_map_pkg::NumBanks-1:0][mem_map_pkg::WordIdxWidth-1:0]  bank_widx_o,
  output logic [mem_map_pkg::NumBanks-1:0][obi_pkg::BeWidth-1:0]           bank_be_o,
  output logic [mem_map_pkg::NumBanks-1:0][obi_pkg::DataWidth-1:0]         bank_wdata_o,
  output logic [obi_pkg::NumMasters-1:0]                                   gnt_q_o,
  output logic [obi_pkg::NumMasters-1:0][mem_map_pkg::BankIdxWidth-1:0]   gnt_bank_q_o
);

  import obi_pkg::*;
  import mem_map_pkg::*;

  logic  [NumMasters-1:0][BankIdxWidth-1:0] mst_bank;
  logic  [NumMasters-1:0][WordIdxWidth-1:0] mst_widx;
  prio_e                                    prio_q [NumBanks];
  prio_e                                    prio_d [NumBanks];
  logic  [NumMasters-1:0]                   gnt_q;
  logic  [NumMasters-1:0][BankIdxWidth-1:0] gnt_bank_q;

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      mst_bank[m] = mst_addr_i[m][BankLsb +: BankIdxWidth];
      mst_widx[m] = mst_addr_i[m][WordLsb +: WordIdxWidth];
    end
  end

  always_comb begin : arb_comb
    logic [NumMasters-1:0] hit;
    logic                  winner;

    hit          = '0;
    winner       = 1'b0;
    mst_gnt_o    = '0;
    bank_req_o   = '0;
    bank_we_o    = '0;
    bank_widx_o  = '0;
    bank_be_o    = '0;
    bank_wdata_o = '0;
    prio_d       = prio_q;
    for (int b = 0; b < NumBanks; b++) begin
      for (int m = 0; m < NumMasters; m++) begin
        hit[m] = mst_req_i[m] && (mst_bank[m] == BankIdxWidth'(b));
      end
      if (&hit) begin
        winner    = (prio_q[b] == PrioM1);
        prio_d[b] = winner ? PrioM0 : PrioM1; // Loser goes first next time
      end else begin
        winner = hit[1];
      end
      if (|hit) begin
        mst_gnt_o[winner] = 1'b1;
        bank_req_o[b]     = 1'b1;
        bank_we_o[b]      = mst_we_i[winner];
        bank_widx_o[b]    = mst_widx[winner];
        bank_be_o[b]      = mst_be_i[winner];
        bank_wdata_o[b]   = mst_wdata_i[winner];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < NumBanks; b++) begin
        prio_q[b] <= PrioM0;
      end
      gnt_q <= '0;
    end else begin
      prio_q <= prio_d;
      gnt_q  <= mst_gnt_o; // Becomes rvalid in the response stage
    end
  end

  // Bank of each grant, only meaningful while the matching gnt_q is set
  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NumMasters; m++) begin
      if (mst_gnt_o[m]) begin
        gnt_bank_q[m] <= mst_bank[m];
      end
    end
  end

  assign gnt_q_o      = gnt_q;
  assign gnt_bank_q_o = gnt_bank_q;

  a_single_owner: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(mst_gnt_o[0] && mst_gnt_o[1] && (mst_bank[0] == mst_bank[1]))
  );

  for (genvar m = 0; m < NumMasters; m++) begin : gen_fair
    // A stalled requestor holds its request and must not starve
    a_no_starve: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      mst_req_i[m] && !mst_gnt_o[m] |-> ##[1:2] mst_gnt_o[m]
    );
  end

endmodule

/* response_router.sv */
/*
 * Response stage. Turns the registered grant of each requestor into rvalid
 * and returns the read data of the bank that grant went to.
 */
`timescale 1ns/10ps

module response_router (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,
  input  logic [obi_pkg::NumMasters-1:0]                               gnt_q_i,
  input  logic [obi_pkg::NumMasters-1:0][mem_map_pkg::BankIdxWidth-1:0] gnt_bank_q_i,
  input  logic [mem_map_pkg::NumBanks-1:0][obi_pkg::DataWidth-1:0]     bank_rdata_i,
  output logic [obi_pkg::NumMasters-1:0]                               mst_rvalid_o,
  output logic [obi_pkg::NumMasters-1:0][obi_pkg::DataWidth-1:0]       mst_rdata_o
);

  import obi_pkg::*;

  always_comb begin
    for (int m = 0; m < NumMasters; m++) begin
      mst_rvalid_o[m] = gnt_q_i[m]; // Exactly one cycle after the grant
      if (gnt_q_i[m]) begin
        mst_rdata_o[m] = bank_rdata_i[gnt_bank_q_i[m]];
      end else begin
        mst_rdata_o[m] = '0;
      end
    end
  end

  // Every response must trace back to a grant whose bank was recorded
  for (genvar m = 0; m < NumMasters; m++) begin : gen_chk
    a_rvalid_after_gnt: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      mst_rvalid_o[m] |-> !$isunknown(gnt_bank_q_i[m])
    );
  end

endmodule

/* memory_subsystem.sv */
/*
 * Banked data memory with two OBI requestors sharing eight SRAM banks.
 * Grant is combinational with the request, rvalid and rdata follow one cycle later.
 */
`timescale 1ns/10ps

module memory_subsystem (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [obi_pkg::NumMasters-1:0]                         mst_req_i,
  input  logic [obi_pkg::NumMasters-1:0]                         mst_we_i,
  input  logic [obi_pkg::NumMasters-1:0][obi_pkg::AddrWidth-1:0] mst_addr_i,
  input  logic [obi_pkg::NumMasters-1:0][obi_pkg::BeWidth-1:0]   mst_be_i,
  input  logic [obi_pkg::NumMasters-1:0][obi_pkg::DataWidth-1:0] mst_wdata_i,
  output logic [obi_pkg::NumMasters-1:0]                         mst_gnt_o,
  output logic [obi_pkg::NumMasters-1:0]                         mst_rvalid_o,
  output logic [obi_pkg::NumMasters-1:0][obi_pkg::DataWidth-1:0] mst_rdata_o
);

  import obi_pkg::*;
  import mem_map_pkg::*;

  // Crossbar to banks
  logic [NumBanks-1:0]                   bank_req;
  logic [NumBanks-1:0]                   bank_we;
  logic [NumBanks-1:0][WordIdxWidth-1:0] bank_widx;
  logic [NumBanks-1:0][BeWidth-1:0]      bank_be;
  logic [NumBanks-1:0][DataWidth-1:0]    bank_wdata;

  // Banks to router
  logic [NumBanks-1:0][DataWidth-1:0] bank_rdata;

  // Crossbar to router
  logic [NumMasters-1:0]                   gnt_q;
  logic [NumMasters-1:0][BankIdxWidth-1:0] gnt_bank_q;

  bank_crossbar bank_crossbar_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mst_req_i    (mst_req_i),
    .mst_we_i     (mst_we_i),
    .mst_addr_i   (mst_addr_i),
    .mst_be_i     (mst_be_i),
    .mst_wdata_i  (mst_wdata_i),
    .mst_gnt_o    (mst_gnt_o),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_widx_o  (bank_widx),
    .bank_be_o    (bank_be),
    .bank_wdata_o (bank_wdata),
    .gnt_q_o      (gnt_q),
    .gnt_bank_q_o (gnt_bank_q)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    sram_wrapper sram_wrapper_i (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_widx[b]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  response_router response_router_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .gnt_q_i      (gnt_q),
    .gnt_bank_q_i (gnt_bank_q),
    .bank_rdata_i (bank_rdata),
    .mst_rvalid_o (mst_rvalid_o),
    .mst_rdata_o  (mst_rdata_o)
  );

endmodule

/* tb_memory_subsystem.sv */
/*
 * Self-checking testbench for the banked memory subsystem. Drives both OBI
 * requestors with LCG stimulus, predicts read data with a shadow memory.
 */
`timescale 1ns/10ps

module tb_memory_subsystem;

  import obi_pkg::*;
  import mem_map_pkg::*;

  localparam int unsigned Timeout = 20;
  localparam int unsigned ConflictOps = 6;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic [NumMasters-1:0]                mst_req;
  logic [NumMasters-1:0]                mst_we;
  logic [NumMasters-1:0][AddrWidth-1:0] mst_addr;
  logic [NumMasters-1:0][BeWidth-1:0]   mst_be;
  logic [NumMasters-1:0][DataWidth-1:0] mst_wdata;
  logic [NumMasters-1:0]                mst_gnt;
  logic [NumMasters-1:0]                mst_rvalid;
  logic [NumMasters-1:0][DataWidth-1:0] mst_rdata;

  logic [7:0]           shadow [NumBytes];
  logic [DataWidth:0]   pend_q [NumMasters][$]; // {is_read, expected word}
  logic                 exp_prio [NumBanks];
  logic [31:0]          lcg_state;
  string                test_name;
  int unsigned          conflicts_seen;
  int unsigned          parallel_seen;
  logic [AddrWidth-1:0] written_q [$];
  logic [AddrWidth-1:0] conf_addr [NumMasters][ConflictOps];
  logic [DataWidth-1:0] conf_data [NumMasters][ConflictOps];

  memory_subsystem memory_subsystem_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mst_req_i    (mst_req),
    .mst_we_i     (mst_we),
    .mst_addr_i   (mst_addr),
    .mst_be_i     (mst_be),
    .mst_wdata_i  (mst_wdata),
    .mst_gnt_o    (mst_gnt),
    .mst_rvalid_o (mst_rvalid),
    .mst_rdata_o  (mst_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("Failure in %s: %s", test_name, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    $display("TB FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [BankIdxWidth-1:0] bank_of(input logic [AddrWidth-1:0] addr);
    return addr[BankLsb +: BankIdxWidth];
  endfunction

  // Upper address bits stay random, they alias onto the same word
  function automatic logic [AddrWidth-1:0] rand_addr(input int bank);
    logic [AddrWidth-1:0] a;
    a = next_rand();
    a[BankLsb +: BankIdxWidth] = bank[BankIdxWidth-1:0];
    a[1:0] = 2'b00;
    return a;
  endfunction

  function automatic logic [31:0] byte_base(input logic [AddrWidth-1:0] addr);
    logic [31:0] base;
    base = addr % NumBytes;
    base[1:0] = 2'b00;
    return base;
  endfunction

  function automatic logic [DataWidth-1:0] shadow_word(input logic [AddrWidth-1:0] addr);
    logic [DataWidth-1:0] w;
    for (int i = 0; i < BeWidth; i++) begin
      w[i*8 +: 8] = shadow[byte_base(addr) + i];
    end
    return w;
  endfunction

  // Called a small delay after a rising edge, returns at the same point
  task automatic issue(input int m, input logic we, input logic [AddrWidth-1:0] addr,
                       input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] wdata);
    int unsigned waited;
    waited       = 0;
    mst_req[m]   = 1'b1;
    mst_we[m]    = we;
    mst_addr[m]  = addr;
    mst_be[m]    = be;
    mst_wdata[m] = wdata;
    @(negedge clk_i);
    while (!mst_gnt[m]) begin
      waited++;
      if (waited >= Timeout) abort_run("request was never granted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    mst_req[m] = 1'b0;
  endtask

  task automatic wait_responses();
    int unsigned waited;
    waited = 0;
    while (pend_q[0].size() != 0 || pend_q[1].size() != 0) begin
      waited++;
      if (waited >= Timeout) abort_run("responses still missing");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  // Mid-cycle sampling, responses first since they belong to the previous grant
  always @(negedge clk_i) begin : monitor
    logic [DataWidth:0] entry;
    logic               winner;
    if (rst_ni) begin
      for (int m = 0; m < NumMasters; m++) begin
        if (mst_rvalid[m]) begin
          if (pend_q[m].size() == 0) abort_run("rvalid without an outstanding request");
          entry = pend_q[m].pop_front();
          if (entry[DataWidth]) begin
            assert (mst_rdata[m] === entry[DataWidth-1:0])
              else report_mismatch("read data", entry[DataWidth-1:0], mst_rdata[m]);
          end
        end
      end
      if (&mst_req && bank_of(mst_addr[0]) == bank_of(mst_addr[1])) begin
        winner = exp_prio[bank_of(mst_addr[0])];
        assert (mst_gnt == (2'b01 << winner))
          else report_mismatch("conflict grant", 32'(2'b01 << winner), 32'(mst_gnt));
        exp_prio[bank_of(mst_addr[0])] = ~winner; // Loser wins the next conflict
        conflicts_seen++;
      end
      if (&(mst_req & mst_gnt) && bank_of(mst_addr[0]) != bank_of(mst_addr[1])) begin
        parallel_seen++;
      end
      for (int m = 0; m < NumMasters; m++) begin
        if (mst_req[m] && mst_gnt[m]) begin
          if (mst_we[m]) begin
            for (int i = 0; i < BeWidth; i++) begin
              if (mst_be[m][i]) shadow[byte_base(mst_addr[m]) + i] = mst_wdata[m][i*8 +: 8];
            end
            pend_q[m].push_back({1'b0, {DataWidth{1'b0}}});
          end else begin
            pend_q[m].push_back({1'b1, shadow_word(mst_addr[m])});
          end
        end
      end
    end
  end

  for (genvar m = 0; m < NumMasters; m++) begin : gen_resp_chk
    a_gnt_needs_req: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !mst_req[m] |-> !mst_gnt[m]
    ) else abort_run("grant without a request");

    a_rvalid_after_gnt: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      mst_req[m] && mst_gnt[m] |=> mst_rvalid[m]
    ) else abort_run("rvalid missing in the cycle after a grant");

    a_rvalid_only_after_gnt: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      mst_rvalid[m] |-> $past(mst_req[m] && mst_gnt[m])
    ) else abort_run("rvalid in a cycle that follows no grant");
  end

  a_parallel_grant: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    &mst_req && bank_of(mst_addr[0]) != bank_of(mst_addr[1]) |-> &mst_gnt
  ) else abort_run("requests to different banks were not both granted");

  a_conflict_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    &mst_req && bank_of(mst_addr[0]) == bank_of(mst_addr[1]) |-> $onehot(mst_gnt)
  ) else abort_run("bank conflict did not grant exactly one requestor");

  initial begin
    logic [AddrWidth-1:0] a;
    logic [31:0]          r;
    logic [DataWidth-1:0] wd0;
    logic [DataWidth-1:0] wd1;
    rst_ni         = 1'b0;
    mst_req        = '0;
    mst_we         = '0;
    mst_addr       = '0;
    mst_be         = '0;
    mst_wdata      = '0;
    lcg_state      = 32'hf9a2_1de8;
    conflicts_seen = 0;
    parallel_seen  = 0;
    test_name      = "reset";
    for (int b = 0; b < NumBanks; b++) begin
      exp_prio[b] = 1'b0; // Requestor 0 first after reset
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    assert (mst_rvalid == '0) else report_mismatch("rvalid in reset", 0, 32'(mst_rvalid));
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (mst_rvalid == '0) else report_mismatch("rvalid after reset", 0, 32'(mst_rvalid));
    assert (mst_gnt == '0) else report_mismatch("gnt after reset", 0, 32'(mst_gnt));
    @(posedge clk_i);
    #1;

    test_name = "write_read";
    for (int i = 0; i < 2 * NumBanks; i++) begin
      a = rand_addr(i % NumBanks);
      written_q.push_back(a);
      issue(0, 1'b1, a, '1, next_rand());
    end
    wait_responses();
    foreach (written_q[i]) issue(0, 1'b0, written_q[i], '0, '0);
    wait_responses();

    test_name = "byte_enable";
    foreach (written_q[i]) begin
      r = next_rand();
      issue(0, 1'b1, written_q[i], r[BeWidth-1:0], next_rand());
      issue(0, 1'b0, written_q[i], '0, '0);
    end
    wait_responses();

    test_name = "parallel";
    for (int i = 0; i < NumBanks; i++) begin
      r   = next_rand();
      wd0 = next_rand();
      wd1 = next_rand();
      fork
        issue(0, 1'b1, written_q[i], r[3:0], wd0);
        issue(1, 1'b1, written_q[(i + 3) % NumBanks], r[7:4], wd1);
      join
      fork
        issue(0, 1'b0, written_q[i], '0, '0);
        issue(1, 1'b0, written_q[(i + 3) % NumBanks], '0, '0);
      join
    end
    wait_responses();
    if (parallel_seen < 2 * NumBanks) abort_run("parallel grants were not reached");

    test_name = "conflict";
    for (int m = 0; m < NumMasters; m++) begin
      for (int k = 0; k < ConflictOps; k++) begin
        conf_addr[m][k] = rand_addr(5);
        conf_data[m][k] = next_rand();
      end
    end
    fork
      for (int k = 0; k < ConflictOps; k++) issue(0, 1'b1, conf_addr[0][k], '1, conf_data[0][k]);
      for (int k = 0; k < ConflictOps; k++) issue(1, 1'b1, conf_addr[1][k], '1, conf_data[1][k]);
    join
    fork
      for (int k = 0; k < ConflictOps; k++) issue(0, 1'b0, conf_addr[1][k], '0, '0);
      for (int k = 0; k < ConflictOps; k++) issue(1, 1'b0, conf_addr[0][k], '0, '0);
    join
    wait_responses();
    if (conflicts_seen < 2 * ConflictOps) abort_run("bank conflicts were not reached");

    test_name = "idle";
    repeat (8) @(posedge clk_i); // No request, so no grant and no rvalid
    #1;

    $display("TB PASSED");
    $finish;
  end

endmodule

/* flist.f */
obi_pkg.sv
mem_map_pkg.sv
sram_wrapper.sv
bank_crossbar.sv
response_router.sv
memory_subsystem.sv
tb_memory_subsystem.sv
